// ==== verif/execCore_golden.txt ====
// Fields in order are instruction, gap, write flag, dst, data, carry, zero and illegal flag
// A gap of f is drawn at random
04A28_0_1_5_0000_0_1_0
84005_0_1_0_0005_0_0_0
8423F_0_1_1_003F_0_0_0
84401_0_1_2_0001_0_0_0
84600_0_1_3_0000_0_1_0
8482A_0_1_4_002A_0_0_0
84A10_0_1_5_0010_0_0_0
84C3C_0_1_6_003C_0_0_0
84E07_1_1_7_0007_0_0_0
04000_0_1_0_0005_0_0_0
04208_0_1_1_003F_0_0_0
04410_0_1_2_0001_0_0_0
04618_0_1_3_0000_0_1_0
04820_0_1_4_002A_0_0_0
04A28_0_1_5_0010_0_0_0
04C30_0_1_6_003C_0_0_0
04E38_0_1_7_0007_0_0_0
186C0_1_1_3_FFFF_0_0_0
0DCD0_0_1_6_0001_1_0_0
0EC08_0_1_6_0045_0_0_0
0CCC0_0_1_6_0004_1_0_0
02CC0_0_1_6_0000_1_1_0
00C00_0_1_6_0005_0_0_0
09C10_0_1_6_0004_1_0_0
0AC80_0_1_6_FFFC_0_0_0
08C00_0_1_6_FFFF_0_0_0
09C90_0_1_6_0000_1_1_0
10C80_0_1_6_0000_1_1_0
12C00_0_1_6_0005_0_0_0
12CC0_0_1_6_FFFE_1_0_0
0ECD8_0_1_6_FFFF_1_0_0
14E00_F_1_7_0000_1_1_0
18F00_F_1_7_FFD5_1_0_0
1CE60_F_1_7_0015_1_0_0
1CF20_F_1_7_0000_1_1_0
20E60_F_1_7_002A_1_0_0
20EA0_F_1_7_0000_1_1_0
24EA0_F_1_7_002B_1_0_0
A0ECF_F_1_7_000F_1_0_0
28E00_0_1_7_0002_1_0_0
28F40_0_1_7_0008_0_0_0
28E80_0_1_7_0000_1_1_0
2CEC0_0_1_7_FFFE_1_0_0
2CE40_0_1_7_007E_0_0_0
2CF00_0_1_7_0054_0_0_0
84221_1_1_1_0021_0_0_0
0C248_1_1_1_0042_0_0_0
0C440_1_1_2_0047_0_0_0
24888_0_1_4_0047_0_0_0
0CAD8_0_1_5_FFFE_1_0_0
0EC00_0_1_6_000B_0_0_0
0ECD0_0_1_6_0046_1_0_0
02CC0_1_1_6_0000_1_1_0
30000_0_0_0_0000_1_1_1
FC200_0_0_0_0000_1_1_1
02C00_0_1_6_0006_0_0_0
04208_0_1_1_0042_0_0_0

// ==== execCore.f ====
hdl/execPkg.sv
hdl/regFile.sv
hdl/alu.sv
hdl/flagUnit.sv
hdl/execControl.sv
hdl/execCore.sv
verif/execCoreChecker.sv
verif/execCoreTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the execCore testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing \
	--top-module execCoreTb \
	-f execCore.f \
	-o execCoreSim \
	&& ./obj_dir/execCoreSim | tee /dev/stderr | grep -q "STATUS: PASS" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// ==== verif/execCoreTb.sv ====
`timescale 1ns/1ps

module execCoreTb;
	import execPkg::*;

	logic clk;
	logic rstN;
	logic instrValid;
	instrWord_t instr;
	wbPort_t wb;
	logic carryFlag;
	logic zeroFlag;
	logic illegalOp;

	int cycle = 0;
	int timeoutLimit = 0;
	int passCount;
	int errorCount;
	int pending;
	int testCount;
	int gap;
	integer seed;

	// Instruction, gap, write, dst, data, carry, zero, illegal as 15 hex digits
	logic [59:0] golden [64];

	execCore uut (
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.instr(instr),
		.wb(wb),
		.carryFlag(carryFlag),
		.zeroFlag(zeroFlag),
		.illegalOp(illegalOp)
	);

	execCoreChecker chk (
		.clk(clk),
		.rstN(rstN),
		.cycle(cycle),
		.wb(wb),
		.carryFlag(carryFlag),
		.zeroFlag(zeroFlag),
		.illegalOp(illegalOp),
		.passCount(passCount),
		.errorCount(errorCount),
		.pending(pending)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	always @(posedge clk) begin
		if (timeoutLimit > 0 && cycle >= timeoutLimit) begin
			$display("run stopped after %0d cycles without finishing", cycle);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	initial begin
		seed = 32'hdb594ae3;
		rstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		// All ones marks the end of the table
		for (int i = 0; i < 64; i++) begin
			golden[i] = '1;
		end
		$readmemh("verif/execCore_golden.txt", golden);
		testCount = 0;
		while (testCount < 64 && golden[testCount] != '1) begin
			testCount++;
		end
		timeoutLimit = 16 + testCount * 6 + 20;

		repeat (16) @(posedge clk);
		#1 rstN = 1'b1;

		for (int i = 0; i < testCount; i++) begin
			@(posedge clk);
			#1;
			instrValid = 1'b1;
			instr = golden[i][59:40];
			chk.addExpected(cycle + 2, golden[i][32], golden[i][30:28], golden[i][27:12],
				golden[i][8], golden[i][4], golden[i][0]);
			if (golden[i][39:36] == 4'hf)
				gap = $unsigned($random(seed)) % 4;
			else
				gap = int'(golden[i][39:36]);
			repeat (gap) begin
				@(posedge clk);
				#1 instrValid = 1'b0;
			end
		end
		@(posedge clk);
		#1 instrValid = 1'b0;

		while (pending != 0) begin
			@(posedge clk);
		end
		// A few more cycles to catch stray pulses
		repeat (3) @(negedge clk);

		$display("tests passed %0d of %0d, errors %0d", passCount, testCount, errorCount);
		if (errorCount == 0 && passCount == testCount) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// ==== verif/execCoreChecker.sv ====
`timescale 1ns/1ps

module execCoreChecker (
	input logic clk,
	input logic rstN,
	input int cycle,
	input execPkg::wbPort_t wb,
	input logic carryFlag,
	input logic zeroFlag,
	input logic illegalOp,
	output int passCount,
	output int errorCount,
	output int pending
);
	import execPkg::*;

	typedef struct packed {
		logic [31:0] due;
		logic write;
		logic [regAddrWidth-1:0] dst;
		logic [dataWidth-1:0] data;
		logic carry;
		logic zero;
		logic illegal;
	} expectEntry_t;

	expectEntry_t expQ [$];
	int testIndex = 0;

	initial begin
		passCount = 0;
		errorCount = 0;
	end

	assign pending = expQ.size();

	// Queued in strobe order, so the front is always the next one due
	task automatic addExpected(input int due, input logic write, input logic [2:0] dst,
			input logic [15:0] data, input logic carry, input logic zero, input logic illegal);
		expectEntry_t e;
		e.due = due;
		e.write = write;
		e.dst = dst;
		e.data = data;
		e.carry = carry;
		e.zero = zero;
		e.illegal = illegal;
		expQ.push_back(e);
	endtask

	// Outputs are registered on the rising edge, so look at the falling one
	always @(negedge clk) begin
		expectEntry_t e;
		logic bad;
		if (rstN) begin
			if (expQ.size() > 0 && expQ[0].due == cycle) begin
				e = expQ.pop_front();
				bad = 1'b0;
				testIndex++;
				if (wb.en != e.write) begin
					bad = 1'b1;
					if (e.write)
						$display("test %0d at %0t: expected write to r%0d did not happen",
							testIndex, $time, e.dst);
					else
						$display("test %0d at %0t: write to r%0d happened but none was expected",
							testIndex, $time, wb.dst);
				end else if (e.write) begin
					if (wb.dst != e.dst) begin
						bad = 1'b1;
						$display("mismatch at %0t: wb.dst got %0d expected %0d",
							$time, wb.dst, e.dst);
					end
					if (wb.data != e.data) begin
						bad = 1'b1;
						$display("mismatch at %0t: wb.data got %h expected %h",
							$time, wb.data, e.data);
					end
				end
				if (carryFlag != e.carry) begin
					bad = 1'b1;
					$display("mismatch at %0t: carryFlag got %b expected %b",
						$time, carryFlag, e.carry);
				end
				if (zeroFlag != e.zero) begin
					bad = 1'b1;
					$display("mismatch at %0t: zeroFlag got %b expected %b",
						$time, zeroFlag, e.zero);
				end
				if (illegalOp != e.illegal) begin
					bad = 1'b1;
					$display("mismatch at %0t: illegalOp got %b expected %b",
						$time, illegalOp, e.illegal);
				end
				if (bad) begin
					errorCount++;
					$display("test %0d failed", testIndex);
				end else begin
					passCount++;
					$display("test %0d passed", testIndex);
				end
			end else if (wb.en || illegalOp) begin
				errorCount++;
				$display("at %0t: output activity with no instruction due", $time);
			end
		end
	end

endmodule

// ==== hdl/execCore.sv ====
`timescale 1ns/1ps

module execCore (
	input logic clk,
	input logic rstN,
	input logic instrValid,
	input execPkg::instrWord_t instr,
	output execPkg::wbPort_t wb,
	output logic carryFlag,
	output logic zeroFlag,
	output logic illegalOp
);
	import execPkg::*;

	logic [regAddrWidth-1:0] rdAddrA;
	logic [regAddrWidth-1:0] rdAddrB;
	logic [dataWidth-1:0] rdDataA;
	logic [dataWidth-1:0] rdDataB;
	aluOp_t op;
	aluResult_t res;

	execControl control (
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.instr(instr),
		.rdAddrA(rdAddrA),
		.rdAddrB(rdAddrB),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB),
		.op(op),
		.res(res),
		.wb(wb),
		.illegalOp(illegalOp)
	);

	regFile regs (
		.clk(clk),
		.rstN(rstN),
		.rdAddrA(rdAddrA),
		.rdAddrB(rdAddrB),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB),
		.wr(wb)
	);

	// The stored carry feeds the unit directly
	alu unit (
		.op(op),
		.carryIn(carryFlag),
		.res(res)
	);

	// op.valid is the stage-2 write enable before it is registered
	flagUnit flags (
		.clk(clk),
		.rstN(rstN),
		.update(op.valid),
		.res(res),
		.carryFlag(carryFlag),
		.zeroFlag(zeroFlag)
	);

endmodule

// ==== hdl/execControl.sv ====
`timescale 1ns/1ps

module execControl (
	input logic clk,
	input logic rstN,
	input logic instrValid,
	input execPkg::instrWord_t instr,
	output logic [2:0] rdAddrA,
	output logic [2:0] rdAddrB,
	input logic [15:0] rdDataA,
	input logic [15:0] rdDataB,
	output execPkg::aluOp_t op,
	input execPkg::aluResult_t res,
	output execPkg::wbPort_t wb,
	output logic illegalOp
);
	import execPkg::*;

	logic isImm;
	logic legal;
	logic [dataWidth-1:0] operandB;
	logic illegalPending;

	function automatic logic funcLegal(input aluFunc_t code);
		case (code)
			funcA, funcB, funcSub, funcAdd, funcAMinusOne, funcZero, funcNot,
			funcXor, funcAnd, funcOr, funcShiftRight, funcShiftLeft: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// Format bit sits in the same place in both forms
	assign isImm = instr.regForm.isImm;
	assign legal = funcLegal(instr.regForm.func);

	assign rdAddrA = instr.regForm.srcA;
	assign rdAddrB = instr.regForm.srcB;

	// Immediate is zero extended
	assign operandB = isImm ?
		{{(dataWidth-immWidth){1'b0}}, instr.immForm.imm} : rdDataB;

	// Stage 1 registers the decoded op
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			op <= '0;
			illegalPending <= 1'b0;
		end else begin
			op.func <= instr.regForm.func;
			op.carrySel <= instr.regForm.carrySel;
			op.instrCin <= instr.regForm.instrCin;
			op.dst <= instr.regForm.dst;
			op.a <= rdDataA;
			op.b <= operandB;
			op.valid <= instrValid && legal;
			illegalPending <= instrValid && !legal;
		end
	end

	// Stage 2 registers the writeback and the illegal pulse
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wb <= '0;
			illegalOp <= 1'b0;
		end else begin
			wb.en <= op.valid;
			wb.dst <= op.dst;
			wb.data <= res.result;
			illegalOp <= illegalPending;
		end
	end

	wbNotIllegal: assert property (
		@(posedge clk) disable iff (!rstN)
		!(wb.en && illegalOp)
	) else $error("writeback and illegalOp high together");

	// A writeback comes two cycles after its strobe
	wbFollowsOp: assert property (
		@(posedge clk) disable iff (!rstN)
		wb.en |-> $past(instrValid, 2)
	) else $error("writeback without a strobe two cycles earlier");

endmodule

// ==== hdl/flagUnit.sv ====
`timescale 1ns/1ps

module flagUnit (
	input logic clk,
	input logic rstN,
	input logic update,
	input execPkg::aluResult_t res,
	output logic carryFlag,
	output logic zeroFlag
);
	import execPkg::*;

	// Logic ops already return the held carry, so one load covers all cases
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			carryFlag <= 1'b0;
			zeroFlag <= 1'b0;
		end else if (update) begin
			carryFlag <= res.carry;
			zeroFlag <= res.zero;
		end
	end

endmodule

// ==== hdl/alu.sv ====
`timescale 1ns/1ps

module alu (
	input execPkg::aluOp_t op,
	input logic carryIn,
	output execPkg::aluResult_t res
);
	import execPkg::*;

	logic cin;
	logic [dataWidth:0] sumA;
	logic [dataWidth:0] sumAdd;
	logic [dataWidth:0] aDec;
	logic [dataWidth-1:0] yArith;
	logic [dataWidth-1:0] yShift;
	logic cArith;
	logic cShift;
	logic isShift;

	// Carry select picks the stored flag or the instruction's own bit
	assign cin = op.carrySel ? carryIn : op.instrCin;

	// 17-bit forms so the carry falls out of the top bit
	assign sumA = {1'b0, op.a} + {{dataWidth{1'b0}}, cin};
	assign sumAdd = {1'b0, op.a} + {1'b0, op.b} + {{dataWidth{1'b0}}, cin};
	assign aDec = {1'b0, op.a} - {{dataWidth{1'b0}}, 1'b1} + {{dataWidth{1'b0}}, cin};

	// Arithmetic and logic group
	always_comb begin
		yArith = '0;
		cArith = carryIn;
		case (op.func)
			funcA: begin
				yArith = sumA[dataWidth-1:0];
				cArith = sumA[dataWidth];
			end
			funcB: begin
				yArith = op.b;
			end
			funcSub: begin
				yArith = aDec[dataWidth-1:0] - op.b;
				// No borrow when a - 1 + cin is not below b
				cArith = $signed(aDec) >= $signed({1'b0, op.b});
			end
			funcAdd: begin
				yArith = sumAdd[dataWidth-1:0];
				cArith = sumAdd[dataWidth];
			end
			funcAMinusOne: begin
				yArith = aDec[dataWidth-1:0];
				cArith = !cin && (op.a != '0);
			end
			funcZero: begin
				yArith = '0;
			end
			funcNot: begin
				yArith = ~op.a;
			end
			funcXor: begin
				yArith = op.a ^ op.b;
			end
			funcAnd: begin
				yArith = op.a & op.b;
			end
			funcOr: begin
				yArith = op.a | op.b;
			end
			default: begin
				yArith = '0;
				cArith = carryIn;
			end
		endcase
	end

	// Shift group moves one place with zero fill
	always_comb begin
		if (op.func == funcShiftLeft) begin
			yShift = {op.a[dataWidth-2:0], 1'b0};
			cShift = op.a[dataWidth-1];
		end else begin
			yShift = {1'b0, op.a[dataWidth-1:1]};
			cShift = op.a[0];
		end
	end

	assign isShift = (op.func == funcShiftRight) || (op.func == funcShiftLeft);

	// Shifter or arithmetic result by function code
	assign res.result = isShift ? yShift : yArith;
	assign res.carry = isShift ? cShift : cArith;
	assign res.zero = (res.result == '0);

endmodule

// ==== hdl/regFile.sv ====
`timescale 1ns/1ps

module regFile (
	input logic clk,
	input logic rstN,
	input logic [2:0] rdAddrA,
	input logic [2:0] rdAddrB,
	output logic [15:0] rdDataA,
	output logic [15:0] rdDataB,
	input execPkg::wbPort_t wr
);
	import execPkg::*;

	logic [dataWidth-1:0] regs [regCount];
	logic hitA;
	logic hitB;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (wr.en) begin
			regs[wr.dst] <= wr.data;
		end
	end

	// Write-through so a read in the writeback cycle sees the new value
	assign hitA = wr.en && (wr.dst == rdAddrA);
	assign hitB = wr.en && (wr.dst == rdAddrB);

	assign rdDataA = hitA ? wr.data : regs[rdAddrA];
	assign rdDataB = hitB ? wr.data : regs[rdAddrB];

	// An enabled write must name a known register
	wrDstKnown: assert property (
		@(posedge clk) disable iff (!rstN)
		wr.en |-> !$isunknown(wr.dst)
	) else $error("regFile write with unknown destination");

endmodule

// ==== hdl/execPkg.sv ====
package execPkg;

	// Sizes of the datapath and the instruction word
	localparam int dataWidth = 16;
	localparam int regCount = 8;
	localparam int regAddrWidth = 3;
	localparam int instrWidth = 20;
	localparam int immWidth = 6;

	// Unused tail of the register form
	localparam int regPadWidth = instrWidth - 8 - 3 * regAddrWidth;

	// Function codes of the 181-style unit and the shifter
	// Bit 0 picks the shift direction inside the shift pair
	typedef enum logic [4:0] {
		funcA = 5'd0,
		funcB = 5'd1,
		funcSub = 5'd2,
		funcAdd = 5'd3,
		funcAMinusOne = 5'd4,
		funcZero = 5'd5,
		funcNot = 5'd6,
		funcXor = 5'd7,
		funcAnd = 5'd8,
		funcOr = 5'd9,
		funcShiftRight = 5'd10,
		funcShiftLeft = 5'd11
	} aluFunc_t;

	// Register form, operand B from the register file
	typedef struct packed {
		logic isImm;
		aluFunc_t func;
		logic carrySel;
		logic instrCin;
		logic [regAddrWidth-1:0] dst;
		logic [regAddrWidth-1:0] srcA;
		logic [regAddrWidth-1:0] srcB;
		logic [regPadWidth-1:0] pad;
	} regInstr_t;

	// Immediate form, operand B is the zero-extended imm
	typedef struct packed {
		logic isImm;
		aluFunc_t func;
		logic carrySel;
		logic instrCin;
		logic [regAddrWidth-1:0] dst;
		logic [regAddrWidth-1:0] srcA;
		logic [immWidth-1:0] imm;
	} immInstr_t;

	typedef union packed {
		regInstr_t regForm;
		immInstr_t immForm;
	} instrWord_t;

	// Decoded operation between stage 1 and stage 2
	typedef struct packed {
		aluFunc_t func;
		logic carrySel;
		logic instrCin;
		logic [regAddrWidth-1:0] dst;
		logic [dataWidth-1:0] a;
		logic [dataWidth-1:0] b;
		logic valid;
	} aluOp_t;

	typedef struct packed {
		logic [dataWidth-1:0] result;
		logic carry;
		logic zero;
	} aluResult_t;

	typedef struct packed {
		logic en;
		logic [regAddrWidth-1:0] dst;
		logic [dataWidth-1:0] data;
	} wbPort_t;

endpackage
